//--- cap_config.svh
`ifndef CAP_CONFIG_SVH
`define CAP_CONFIG_SVH

// receive slots, at most 4
`define CAP_NUM_SLOTS 2

// buffer words per slot, first words of a region are registers
`define CAP_BUF_AW    10
`define CAP_HDR_WORDS 4
`define CAP_MAX_BYTES (((1 << `CAP_BUF_AW) - `CAP_HDR_WORDS) * 2)

// data widths
`define CAP_CNT_W  64
`define CAP_TS_W   32
`define CAP_LEN_W  12
`define CAP_DROP_W 16
`define CAP_WORD_W 16
`define CAP_APB_AW 16

`endif

//--- apb_pkg.sv
`include "cap_config.svh"

package apb_pkg;

  typedef logic [`CAP_APB_AW-1:0]   apb_addr_t;
  typedef logic [`CAP_WORD_W-1:0]   apb_data_t;
  typedef logic [`CAP_WORD_W/8-1:0] apb_strb_t;

  // host to slave
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_strb_t pstrb;
  } apb_req_t;

  // slave to host
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
  } apb_rsp_t;

endpackage

//--- cap_pkg.sv
`include "cap_config.svh"

package cap_pkg;

  typedef logic [7:0]                rx_byte_t;
  typedef logic [`CAP_TS_W-1:0]      ts_t;
  typedef logic [`CAP_LEN_W-1:0]     frame_len_t;
  typedef logic [`CAP_WORD_W-1:0]    buf_word_t;
  typedef logic [`CAP_BUF_AW-1:0]    buf_addr_t;
  typedef logic [`CAP_CNT_W-1:0]     glob_cnt_t;
  typedef logic [`CAP_DROP_W-1:0]    drop_cnt_t;

  // one GMII beat
  typedef struct packed {
    logic     valid;
    rx_byte_t data;
  } rx_beat_t;

  typedef enum logic [1:0] {
    st_idle,
    st_armed,
    st_receiving,
    st_done
  } slot_state_e;

  // per slot read data back to the register block
  typedef struct packed {
    ts_t        ts;
    frame_len_t len;
    buf_word_t  rd_data;
  } slot_info_t;

endpackage

//--- rx_dispatch.sv
`timescale 1ns/1ps
`include "cap_config.svh"

module rx_dispatch (
  input  logic                        clk_125,
  input  logic                        core_rst_n,
  input  cap_pkg::rx_beat_t           rx_beat_i,
  input  logic [`CAP_NUM_SLOTS-1:0]   slot_armed_i,
  output cap_pkg::rx_beat_t           beat_o,
  output logic [`CAP_NUM_SLOTS-1:0]   slot_sel_o,
  output cap_pkg::drop_cnt_t          drop_count_o
);

  import cap_pkg::*;

  rx_beat_t                  beat_q;
  logic [`CAP_NUM_SLOTS-1:0] sel_q;
  logic [`CAP_NUM_SLOTS-1:0] lowest_armed;
  drop_cnt_t                 drop_q;
  logic                      frame_start;

  // rising edge of valid marks a new frame
  assign frame_start = rx_beat_i.valid && !beat_q.valid;

  // isolate the lowest set bit
  assign lowest_armed = slot_armed_i & (~slot_armed_i + 1'b1);

  // --------------------
  // stream register and slot choice
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      beat_q <= '0;
      sel_q  <= '0;
      drop_q <= '0;
    end else begin
      beat_q <= rx_beat_i;
      if (frame_start) begin
        sel_q <= lowest_armed;
        // nobody armed, frame is lost
        if (lowest_armed == '0) begin
          drop_q <= drop_q + 1'b1;
        end
      end else if (!rx_beat_i.valid) begin
        sel_q <= '0;
      end
    end
  end

  assign beat_o       = beat_q;
  assign slot_sel_o   = sel_q;
  assign drop_count_o = drop_q;

endmodule

//--- rx_slot.sv
`timescale 1ns/1ps
`include "cap_config.svh"

module rx_slot (
  input  logic                 clk_125,
  input  logic                 core_rst_n,
  input  cap_pkg::rx_beat_t    beat_i,
  input  logic                 sel_i,
  input  logic                 arm_i,
  input  cap_pkg::ts_t         counter_i,
  input  cap_pkg::buf_addr_t   rd_addr_i,
  output cap_pkg::slot_state_e state_o,
  output logic                 armed_o,
  output cap_pkg::slot_info_t  info_o
);

  import cap_pkg::*;

  localparam int unsigned BUF_DEPTH = 1 << `CAP_BUF_AW;

  slot_state_e state_q;
  frame_len_t  byte_cnt_q;
  ts_t         ts_q;
  logic        first_beat;
  logic        take_beat;
  logic        buf_full;

  logic [1:0]  wr_be_q;
  buf_addr_t   wr_addr_q;
  buf_word_t   wr_data_q;
  buf_word_t   rd_data_q;
  buf_word_t   buf_mem [BUF_DEPTH];

  assign first_beat = (state_q == st_armed) && sel_i && beat_i.valid;
  assign take_beat  = first_beat || ((state_q == st_receiving) && beat_i.valid);
  assign buf_full   = byte_cnt_q >= frame_len_t'(`CAP_MAX_BYTES);

  // --------------------
  // arm / done FSM
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      state_q    <= st_idle;
      byte_cnt_q <= '0;
      wr_be_q    <= '0;
    end else begin
      wr_be_q <= '0;
      case (state_q)
        st_idle, st_done: begin
          if (arm_i) begin
            state_q    <= st_armed;
            byte_cnt_q <= '0;
          end
        end
        st_armed: begin
          if (first_beat) begin
            state_q <= st_receiving;
          end
        end
        st_receiving: begin
          // first idle cycle closes the frame
          if (!beat_i.valid) begin
            state_q <= st_done;
          end
        end
        default: state_q <= st_idle;
      endcase

      // bytes past the buffer end are dropped, length saturates
      if (take_beat && !buf_full) begin
        wr_be_q    <= byte_cnt_q[0] ? 2'b10 : 2'b11;
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
    end
  end

  // write request and timestamp
  always_ff @(posedge clk_125) begin
    if (take_beat) begin
      wr_addr_q <= buf_addr_t'(byte_cnt_q >> 1) + buf_addr_t'(`CAP_HDR_WORDS);
      // even byte also clears the high half
      if (byte_cnt_q[0]) begin
        wr_data_q <= {beat_i.data, 8'h00};
      end else begin
        wr_data_q <= {8'h00, beat_i.data};
      end
    end
    if (first_beat) begin
      ts_q <= counter_i;
    end
  end

  // --------------------
  // frame buffer
  // --------------------
  always_ff @(posedge clk_125) begin
    if (wr_be_q[0]) begin
      buf_mem[wr_addr_q][7:0] <= wr_data_q[7:0];
    end
    if (wr_be_q[1]) begin
      buf_mem[wr_addr_q][15:8] <= wr_data_q[15:8];
    end
    rd_data_q <= buf_mem[rd_addr_i];
  end

  assign state_o        = state_q;
  assign armed_o        = state_q == st_armed;
  assign info_o.ts      = ts_q;
  assign info_o.len     = byte_cnt_q;
  assign info_o.rd_data = rd_data_q;

endmodule

//--- cap_regs.sv
`timescale 1ns/1ps
`include "cap_config.svh"

module cap_regs (
  input  logic                                       clk_125,
  input  logic                                       core_rst_n,
  input  apb_pkg::apb_req_t                          apb_req_i,
  output apb_pkg::apb_rsp_t                          apb_rsp_o,
  input  cap_pkg::slot_state_e [`CAP_NUM_SLOTS-1:0]  slot_state_i,
  input  cap_pkg::slot_info_t  [`CAP_NUM_SLOTS-1:0]  slot_info_i,
  input  cap_pkg::drop_cnt_t                         drop_count_i,
  output logic [`CAP_NUM_SLOTS-1:0]                  arm_o,
  output cap_pkg::ts_t                               counter_o,
  output cap_pkg::buf_addr_t                         rd_addr_o,
  output logic                                       irq_o
);

  import apb_pkg::*;
  import cap_pkg::*;

  localparam int unsigned NUM_SLOTS = `CAP_NUM_SLOTS;
  localparam int unsigned HDR_WORDS = `CAP_HDR_WORDS;
  localparam int unsigned BUF_WORDS = 1 << `CAP_BUF_AW;

  glob_cnt_t            counter_q;
  logic                 access;
  logic                 wait_q;
  logic                 is_glob;
  logic                 is_slot;
  logic                 is_buf;
  logic                 glob_wr;
  logic                 cnt_wr;
  logic [11:0]          word_off;
  logic [1:0]           slot_idx;
  logic [1:0]           cnt_word;
  logic [NUM_SLOTS-1:0] done_vec;
  apb_data_t            status;
  apb_data_t            rdata;
  slot_info_t           info;

  // --------------------
  // address decode
  // --------------------
  assign access   = apb_req_i.psel && apb_req_i.penable;
  assign word_off = apb_req_i.paddr[12:1];
  assign slot_idx = apb_req_i.paddr[14:13];
  assign is_glob  = apb_req_i.paddr[15:13] == 3'b000;
  assign is_slot  = apb_req_i.paddr[15] && (int'(slot_idx) < NUM_SLOTS);
  assign is_buf   = is_slot && (word_off >= 12'(HDR_WORDS)) && (word_off < 12'(BUF_WORDS));

  assign glob_wr  = access && apb_req_i.pwrite && is_glob;
  assign cnt_wr   = glob_wr && (word_off >= 12'd1) && (word_off <= 12'd4);
  // word 1..4 map to counter lanes 0..3
  assign cnt_word = word_off[1:0] - 2'd1;

  // one wait state on buffer accesses for the registered read
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= access && is_buf && !wait_q;
    end
  end

  assign apb_rsp_o.pready = access && (!is_buf || wait_q);
  assign apb_rsp_o.prdata = rdata;
  assign rd_addr_o        = buf_addr_t'(word_off);

  // --------------------
  // global counter
  // --------------------
  always_ff @(posedge clk_125 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      counter_q <= '0;
    end else if (cnt_wr) begin
      for (int b = 0; b < 2; b++) begin
        if (apb_req_i.pstrb[b]) begin
          counter_q[16*cnt_word + 8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
        end
      end
    end else begin
      counter_q <= counter_q + 1'b1;
    end
  end

  assign counter_o = counter_q[`CAP_TS_W-1:0];

  // status bits, arm pulses and interrupt
  always_comb begin
    status   = '0;
    arm_o    = '0;
    done_vec = '0;
    for (int n = 0; n < NUM_SLOTS; n++) begin
      status[2*n]   = slot_state_i[n] == st_armed;
      status[2*n+1] = slot_state_i[n] == st_done;
      done_vec[n]   = slot_state_i[n] == st_done;
      arm_o[n]      = glob_wr && (word_off == 12'd0) && apb_req_i.pstrb[0] &&
                      apb_req_i.pwdata[2*n];
    end
  end

  assign irq_o = |done_vec;

  // --------------------
  // read mux
  // --------------------
  always_comb begin
    rdata = '0;
    info  = '0;
    if (is_glob) begin
      case (word_off)
        12'd0:   rdata = status;
        12'd1:   rdata = counter_q[15:0];
        12'd2:   rdata = counter_q[31:16];
        12'd3:   rdata = counter_q[47:32];
        12'd4:   rdata = counter_q[63:48];
        12'd5:   rdata = drop_count_i;
        default: rdata = '0;
      endcase
    end else if (is_slot) begin
      info = slot_info_i[slot_idx];
      case (word_off)
        12'd0:   rdata = info.ts[15:0];
        12'd1:   rdata = info.ts[31:16];
        12'd2:   rdata = apb_data_t'(info.len);
        12'd3:   rdata = '0;
        default: rdata = is_buf ? info.rd_data : '0;
      endcase
    end
  end

endmodule

//--- frame_capture_top.sv
`timescale 1ns/1ps
`include "cap_config.svh"

module frame_capture_top (
  input  logic              clk_125,
  input  logic              core_rst_n,
  input  apb_pkg::apb_req_t apb_req_i,
  output apb_pkg::apb_rsp_t apb_rsp_o,
  input  cap_pkg::rx_beat_t rx_beat_i,
  output logic              irq_o
);

  import cap_pkg::*;

  rx_beat_t                            beat;
  logic [`CAP_NUM_SLOTS-1:0]           slot_sel;
  logic [`CAP_NUM_SLOTS-1:0]           armed_vec;
  logic [`CAP_NUM_SLOTS-1:0]           arm;
  drop_cnt_t                           drop_count;
  ts_t                                 counter;
  buf_addr_t                           rd_addr;
  slot_state_e [`CAP_NUM_SLOTS-1:0]    slot_state;
  slot_info_t  [`CAP_NUM_SLOTS-1:0]    slot_info;

  rx_dispatch u_dispatch (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .rx_beat_i    (rx_beat_i),
    .slot_armed_i (armed_vec),
    .beat_o       (beat),
    .slot_sel_o   (slot_sel),
    .drop_count_o (drop_count)
  );

  // --------------------
  // receive slots
  // --------------------
  for (genvar i = 0; i < `CAP_NUM_SLOTS; i++) begin : g_slot
    rx_slot u_slot (
      .clk_125    (clk_125),
      .core_rst_n (core_rst_n),
      .beat_i     (beat),
      .sel_i      (slot_sel[i]),
      .arm_i      (arm[i]),
      .counter_i  (counter),
      .rd_addr_i  (rd_addr),
      .state_o    (slot_state[i]),
      .armed_o    (armed_vec[i]),
      .info_o     (slot_info[i])
    );
  end

  cap_regs u_regs (
    .clk_125      (clk_125),
    .core_rst_n   (core_rst_n),
    .apb_req_i    (apb_req_i),
    .apb_rsp_o    (apb_rsp_o),
    .slot_state_i (slot_state),
    .slot_info_i  (slot_info),
    .drop_count_i (drop_count),
    .arm_o        (arm),
    .counter_o    (counter),
    .rd_addr_o    (rd_addr),
    .irq_o        (irq_o)
  );

endmodule

//--- tb_frame_capture.sv
`timescale 1ns/1ps
`include "cap_config.svh"

module tb_frame_capture;

  import apb_pkg::*;
  import cap_pkg::*;

  localparam int NUM_FRAMES = 5;
  localparam int MAX_BYTES  = `CAP_MAX_BYTES;

  typedef struct packed {
    logic [11:0] len;
    logic [1:0]  arm;
    logic        drop;
    logic [1:0]  slot;
  } frame_entry_t;

  logic         clk_125;
  logic         core_rst_n;
  apb_req_t     apb_req;
  apb_rsp_t     apb_rsp;
  rx_beat_t     rx_beat;
  logic         irq_o;

  frame_entry_t frames [NUM_FRAMES];
  logic [7:0]   frame_bytes [0:2047];
  logic [1:0]   exp_armed;
  logic [1:0]   exp_done;
  int           exp_len [2];
  int           exp_drop;
  int           seed;
  int           err_cnt;
  int unsigned  cycle_cnt;
  int unsigned  cycle_limit;

  frame_capture_top dut0 (
    .clk_125    (clk_125),
    .core_rst_n (core_rst_n),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .rx_beat_i  (rx_beat),
    .irq_o      (irq_o)
  );

  always #10 clk_125 = ~clk_125;

  always @(posedge clk_125) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout, run did not finish within %0d cycles", cycle_limit);
      stop_run();
    end
  end

  // --------------------
  // reporting
  // --------------------
  task stop_run();
    err_cnt = err_cnt + 1;
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%h expected 0x%h", name, got, exp);
      stop_run();
    end
  endtask

  // --------------------
  // APB host
  // --------------------
  task automatic wait_ready();
    @(negedge clk_125);
    while (!apb_rsp.pready) begin
      @(negedge clk_125);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input apb_strb_t strb);
    @(posedge clk_125);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b1;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= data;
    apb_req.pstrb   <= strb;
    @(posedge clk_125);
    apb_req.penable <= 1'b1;
    wait_ready();
    @(posedge clk_125);
    apb_req <= '0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge clk_125);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= 1'b0;
    apb_req.paddr   <= addr;
    apb_req.pstrb   <= '0;
    @(posedge clk_125);
    apb_req.penable <= 1'b1;
    wait_ready();
    data = apb_rsp.prdata;
    @(posedge clk_125);
    apb_req <= '0;
  endtask

  // --------------------
  // model checks
  // --------------------
  task automatic check_status();
    apb_data_t d;
    apb_data_t exp;
    exp = '0;
    for (int n = 0; n < 2; n++) begin
      exp[2*n]   = exp_armed[n];
      exp[2*n+1] = exp_done[n];
    end
    apb_read(16'h0000, d);
    compare("status", d, exp);
    @(negedge clk_125);
    compare("irq_o", irq_o, |exp_done);
  endtask

  // high word read twice so the low word belongs to it
  task automatic read_counter_low(output logic [31:0] value);
    apb_data_t hi1;
    apb_data_t hi2;
    apb_data_t lo;
    hi1 = '0;
    hi2 = '1;
    while (hi1 !== hi2) begin
      apb_read(16'h0004, hi1);
      apb_read(16'h0002, lo);
      apb_read(16'h0004, hi2);
    end
    value = {hi1, lo};
  endtask

  task automatic check_counter();
    apb_data_t a;
    apb_data_t b;
    apb_write(16'h0008, 16'hA5C3, 2'b11);
    apb_write(16'h0006, 16'h1234, 2'b11);
    // low lane only, high byte keeps 0x12
    apb_write(16'h0006, 16'hEE77, 2'b01);
    apb_read(16'h0008, a);
    compare("counter word 3", a, 16'hA5C3);
    apb_read(16'h0006, a);
    compare("counter word 2", a, 16'h1277);
    apb_read(16'h0002, a);
    apb_read(16'h0002, b);
    if (b <= a) begin
      $display("counter word 0 did not increase between two reads");
      stop_run();
    end
  endtask

  task automatic check_slot(input int slot, input int stored, input logic [31:0] ts_lo,
                            input logic [31:0] ts_hi);
    apb_addr_t base;
    apb_data_t d;
    apb_data_t lo;
    apb_data_t exp;
    base = apb_addr_t'(16'h8000 + slot * 16'h2000);
    apb_read(base + 16'h4, d);
    compare($sformatf("slot%0d length", slot), d, stored);
    apb_read(base, lo);
    apb_read(base + 16'h2, d);
    if ({d, lo} < ts_lo || {d, lo} > ts_hi) begin
      $display("slot %0d timestamp %h lies outside %h to %h", slot, {d, lo}, ts_lo, ts_hi);
      stop_run();
    end
    for (int w = 0; w < (stored + 1) / 2; w++) begin
      exp = {8'h00, frame_bytes[2*w]};
      if (2*w + 1 < stored) begin
        exp[15:8] = frame_bytes[2*w+1];
      end
      apb_read(base + 16'h8 + apb_addr_t'(2*w), d);
      compare($sformatf("slot%0d word %0d", slot, w), d, exp);
    end
  endtask

  task automatic send_frame(input int len);
    for (int k = 0; k < len; k++) begin
      @(posedge clk_125);
      rx_beat <= {1'b1, frame_bytes[k]};
    end
    @(posedge clk_125);
    rx_beat <= '0;
  endtask

  task automatic run_entry(input frame_entry_t e);
    apb_data_t   d;
    logic [31:0] ts_before;
    logic [31:0] ts_after;
    int          rnd;
    int          stored;
    if (e.arm != 2'b00) begin
      apb_write(16'h0000, {12'h000, 1'b0, e.arm[1], 1'b0, e.arm[0]}, 2'b01);
      exp_armed = exp_armed | e.arm;
      exp_done  = exp_done & ~e.arm;
      check_status();
    end
    for (int k = 0; k < int'(e.len); k++) begin
      rnd            = $random(seed);
      frame_bytes[k] = rnd[7:0];
    end
    stored = (e.len > MAX_BYTES) ? MAX_BYTES : int'(e.len);
    read_counter_low(ts_before);
    send_frame(e.len);
    if (e.drop) begin
      exp_drop = exp_drop + 1;
      d = '0;
      while (int'(d) != exp_drop) begin
        apb_read(16'h000A, d);
      end
      check_status();
      for (int n = 0; n < 2; n++) begin
        apb_read(apb_addr_t'(16'h8004 + n * 16'h2000), d);
        compare($sformatf("slot%0d length", n), d, exp_len[n]);
      end
    end else begin
      d = '0;
      while (!d[2*e.slot+1]) begin
        apb_read(16'h0000, d);
      end
      read_counter_low(ts_after);
      exp_armed[e.slot]  = 1'b0;
      exp_done[e.slot]   = 1'b1;
      exp_len[e.slot]    = stored;
      check_status();
      check_slot(e.slot, stored, ts_before, ts_after);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    apb_data_t d;
    clk_125    = 1'b0;
    core_rst_n = 1'b0;
    apb_req    = '0;
    rx_beat    = '0;
    seed       = 88258;
    err_cnt    = 0;
    cycle_cnt  = 0;
    exp_armed  = '0;
    exp_done   = '0;
    exp_len    = '{0, 0};
    exp_drop   = 0;

    frames[0] = '{12'd64,   2'b01, 1'b0, 2'd0};
    frames[1] = '{12'd61,   2'b11, 1'b0, 2'd0};
    frames[2] = '{12'd33,   2'b00, 1'b0, 2'd1};
    frames[3] = '{12'd20,   2'b00, 1'b1, 2'd0};
    frames[4] = '{12'd2046, 2'b11, 1'b0, 2'd0};

    // each byte is sent once and read back as half of a four cycle word read
    cycle_limit = 0;
    for (int i = 0; i < NUM_FRAMES; i++) begin
      cycle_limit = cycle_limit + 3 * frames[i].len + 400;
    end

    repeat (16) @(posedge clk_125);
    core_rst_n <= 1'b1;

    @(negedge clk_125);
    compare("pready", apb_rsp.pready, 1'b0);
    check_status();
    apb_read(16'h000A, d);
    compare("drop count", d, 16'h0000);

    check_counter();

    for (int i = 0; i < NUM_FRAMES; i++) begin
      run_entry(frames[i]);
    end

    if (err_cnt == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_run();
    end
  end

endmodule

//--- sim.f
+incdir+.
apb_pkg.sv
cap_pkg.sv
rx_dispatch.sv
rx_slot.sv
cap_regs.sv
frame_capture_top.sv
tb_frame_capture.sv

//--- Bender.yml
package:
  name: frame_capture

sources:
  - include_dirs:
      - .
    files:
      - apb_pkg.sv
      - cap_pkg.sv
      - rx_dispatch.sv
      - rx_slot.sv
      - cap_regs.sv
      - frame_capture_top.sv
      - target: test
        files:
          - tb_frame_capture.sv
